// ==== sim.f ====
+incdir+rtl
rtl/rv_pkg.sv
rtl/decode_if.sv
rtl/instr_decoder.sv
rtl/alu_execute.sv
rtl/reg_file.sv
rtl/rv_decode_exec_top.sv
test/tb_checker.sv
test/tb_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the decode/execute testbench with verilator

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_top -f sim.f -Mdir obj_dir \
	> "$build_log" 2>&1
if [ $? -ne 0 ]; then
	cat "$build_log"
	echo "build failed"
	exit 1
fi

./obj_dir/Vtb_top > "$sim_log" 2>&1
run_status=$?
cat "$sim_log"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" "$sim_log"; then
	exit 1
fi
exit 0

// ==== test/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;
	import rv_pkg::*;

	localparam int NUM_TESTS = 6;

	logic        clk;
	logic        i_reset;
	logic        i_valid;
	logic [31:0] i_instr;
	logic [31:0] i_pc;
	logic        o_wb_valid;
	logic        o_wb_write;
	logic [4:0]  o_wb_rd;
	logic [31:0] o_wb_data;
	logic        o_branch_taken;
	logic [31:0] o_target;
	logic        o_illegal;
	int          errors;
	int          passes;
	int          pending;
	int          test_len [NUM_TESTS];
	int          total_len;
	int          limit_cycles = 0;
	logic [4:0]  last_rd;

	rv_decode_exec_top dut0 (
		.clk            (clk),
		.i_reset        (i_reset),
		.i_valid        (i_valid),
		.i_instr        (i_instr),
		.i_pc           (i_pc),
		.o_wb_valid     (o_wb_valid),
		.o_wb_write     (o_wb_write),
		.o_wb_rd        (o_wb_rd),
		.o_wb_data      (o_wb_data),
		.o_branch_taken (o_branch_taken),
		.o_target       (o_target),
		.o_illegal      (o_illegal)
	);

	tb_checker chk0 (
		.clk            (clk),
		.i_reset        (i_reset),
		.i_valid        (i_valid),
		.i_instr        (i_instr),
		.i_pc           (i_pc),
		.i_wb_valid     (o_wb_valid),
		.i_wb_write     (o_wb_write),
		.i_wb_rd        (o_wb_rd),
		.i_wb_data      (o_wb_data),
		.i_branch_taken (o_branch_taken),
		.i_target       (o_target),
		.i_illegal      (o_illegal),
		.o_errors       (errors),
		.o_passes       (passes),
		.o_pending      (pending)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// I-type layout that R-type shares with {funct7, rs2} as the upper field
	function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
			input opcode_e op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
	endfunction

	function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
	endfunction

	function automatic logic known_opcode(input logic [6:0] op);
		return op == OP || op == OP_IMM || op == LUI || op == AUIPC || op == JAL ||
			op == JALR || op == BRANCH;
	endfunction

	// one random instruction of the given test kind
	function automatic logic [31:0] make_instr(input int kind);
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [6:0]  op7;
		logic [31:0] word;
		rd = 5'($urandom);
		rs1 = 5'($urandom);
		rs2 = 5'($urandom);
		f3 = 3'($urandom);
		f7 = ($urandom % 2 == 0) ? 7'h00 : 7'h20;
		case (kind)
			0: word = i_word(12'($urandom), ($urandom % 2 == 0) ? 5'd0 : rs1, 3'b000, rd, OP_IMM);
			1, 2: begin
				if (kind == 2) begin
					rs1 = last_rd;
					rd = (rd == 5'd0) ? 5'd1 : rd;
					last_rd = rd;
				end
				// the alternate funct7 only exists for sub and the arithmetic shifts
				if (f3 != 3'b000 && f3 != 3'b101) f7 = 7'h00;
				if ($urandom % 2 == 0 || f3 == 3'b001 || f3 == 3'b101) begin
					word = i_word({f7, rs2}, rs1, f3, rd, ($urandom % 2 == 0) ? OP : OP_IMM);
				end else begin
					word = i_word(12'($urandom), rs1, f3, rd, OP_IMM);
				end
			end
			3: begin
				case ($urandom % 4)
					0: word = u_word(20'($urandom), rd, LUI);
					1: word = u_word(20'($urandom), rd, AUIPC);
					2: word = j_word(21'($urandom), rd);
					default: word = i_word(12'($urandom), rs1, 3'b000, rd, JALR);
				endcase
			end
			4: begin
				// maps 0..5 onto beq, bne, blt, bge, bltu, bgeu
				f3 = 3'($urandom % 6);
				if (f3 >= 3'd2) f3 = f3 + 3'd2;
				if ($urandom % 4 == 0) rs2 = rs1;
				word = b_word(13'($urandom), rs2, rs1, f3);
			end
			default: begin
				if ($urandom % 2 == 0) begin
					// addi x0 shows a register on o_wb_data without changing state
					word = i_word(12'd0, rs1, 3'b000, 5'd0, OP_IMM);
				end else begin
					do op7 = 7'($urandom); while (known_opcode(op7));
					word = {25'($urandom), op7};
				end
			end
		endcase
		return word;
	endfunction

	task automatic run_test(input int num, input string name, input int count);
		int issued;
		int density;
		int err_before;
		issued = 0;
		density = (num == 2) ? 100 : 50 + int'($urandom % 51);
		err_before = errors;
		while (issued < count) begin
			@(posedge clk);
			if (int'($urandom % 100) < density) begin
				i_valid <= 1'b1;
				i_instr <= make_instr(num);
				i_pc <= $urandom & 32'hffff_fffc;
				issued++;
			end else begin
				i_valid <= 1'b0;
			end
		end
		@(posedge clk);
		i_valid <= 1'b0;
		@(posedge clk);
		wait (pending == 0);
		$display("test %0d %s: %0d instructions, %0d errors", num, name, count,
			errors - err_before);
	endtask

	// watchdog sized from the total instruction count
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", limit_cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		string names [NUM_TESTS];
		void'($urandom(32'hee87));
		i_reset = 1'b1;
		i_valid = 1'b0;
		i_instr = '0;
		i_pc = '0;
		last_rd = '0;
		names = '{"addi_load", "alu_random", "back_to_back", "upper_and_jumps",
			"branches", "illegal_opcodes"};
		total_len = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			test_len[t] = 20 + int'($urandom % 41);
			total_len += test_len[t];
		end
		limit_cycles = total_len * 4 + 100 * NUM_TESTS;
		repeat (2) @(posedge clk);
		i_reset <= 1'b0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			run_test(t, names[t], test_len[t]);
		end
		repeat (2) @(posedge clk);
		$display("summary: %0d checks passed, %0d errors", passes, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== test/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker (
	input  logic        clk,
	input  logic        i_reset,
	input  logic        i_valid,
	input  logic [31:0] i_instr,
	input  logic [31:0] i_pc,
	input  logic        i_wb_valid,
	input  logic        i_wb_write,
	input  logic [4:0]  i_wb_rd,
	input  logic [31:0] i_wb_data,
	input  logic        i_branch_taken,
	input  logic [31:0] i_target,
	input  logic        i_illegal,
	output int          o_errors,
	output int          o_passes,
	output int          o_pending
);
	import rv_pkg::*;

	typedef struct packed {
		int          due;
		logic        write;
		logic [4:0]  rd;
		logic [31:0] data;
		logic        taken;
		logic        has_target;
		logic [31:0] target;
		logic        illegal;
	} expect_t;

	logic [31:0] model_regs [32];
	expect_t     exp_q [$];
	int          cycle = 0;
	int          pushed = 0;
	int          popped = 0;
	int          err_count = 0;
	int          pass_count = 0;

	assign o_errors = err_count;
	assign o_passes = pass_count;
	assign o_pending = pushed - popped;

	// RV32I funct3 arithmetic, alt selects sub or the arithmetic right shift
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000:  return alt ? a - b : a + b;
			3'b001:  return a << b[4:0];
			3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011:  return (a < b) ? 32'd1 : 32'd0;
			3'b100:  return a ^ b;
			3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic model_exec(input logic [31:0] instr, input logic [31:0] pc);
		expect_t     e;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_b;
		logic [31:0] imm_j;
		logic        legal;
		f3 = instr[14:12];
		f7 = instr[31:25];
		a = model_regs[instr[19:15]];
		b = model_regs[instr[24:20]];
		imm_i = {{20{instr[31]}}, instr[31:20]};
		imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
		imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
		e = '0;
		e.due = cycle + 1;
		e.rd = instr[11:7];
		e.write = 1'b1;
		legal = 1'b1;
		case (instr[6:0])
			OP: begin
				legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
				e.data = alu_ref(f3, f7[5], a, b);
			end
			OP_IMM: begin
				if (f3 == 3'b001) legal = (f7 == 7'h00);
				if (f3 == 3'b101) legal = (f7 == 7'h00 || f7 == 7'h20);
				if (f3 == 3'b001 || f3 == 3'b101) begin
					e.data = alu_ref(f3, f7[5], a, {27'd0, instr[24:20]});
				end else begin
					e.data = alu_ref(f3, 1'b0, a, imm_i);
				end
			end
			LUI:   e.data = {instr[31:12], 12'd0};
			AUIPC: e.data = pc + {instr[31:12], 12'd0};
			JAL: begin
				e.data = pc + 32'd4;
				e.taken = 1'b1;
				e.has_target = 1'b1;
				e.target = pc + imm_j;
			end
			JALR: begin
				legal = (f3 == 3'b000);
				e.data = pc + 32'd4;
				e.taken = 1'b1;
				e.has_target = 1'b1;
				e.target = (a + imm_i) & ~32'd1;
			end
			BRANCH: begin
				e.write = 1'b0;
				e.has_target = 1'b1;
				e.target = pc + imm_b;
				case (f3)
					3'b000:  e.taken = (a == b);
					3'b001:  e.taken = (a != b);
					3'b100:  e.taken = ($signed(a) < $signed(b));
					3'b101:  e.taken = ($signed(a) >= $signed(b));
					3'b110:  e.taken = (a < b);
					3'b111:  e.taken = (a >= b);
					default: legal = 1'b0;
				endcase
			end
			default: legal = 1'b0;
		endcase
		if (!legal) begin
			e.write = 1'b0;
			e.taken = 1'b0;
			e.has_target = 1'b0;
			e.illegal = 1'b1;
		end
		// x0 stays zero in the model
		if (e.write && e.rd != 5'd0) model_regs[e.rd] = e.data;
		exp_q.push_back(e);
		pushed++;
	endtask

	task automatic compare_value(input string name, input logic [31:0] exp_val,
			input logic [31:0] act_val);
		if (exp_val !== act_val) begin
			err_count++;
			$display("ERROR at %0t: %s expected 0x%08h, actual 0x%08h", $time, name,
				exp_val, act_val);
		end else begin
			pass_count++;
		end
	endtask

	// instructions are taken in the same edge the DUT samples them
	always @(posedge clk) begin
		if (i_reset) begin
			cycle = 0;
			for (int i = 0; i < 32; i++) model_regs[i] = '0;
		end else begin
			cycle = cycle + 1;
			if (i_valid) model_exec(i_instr, i_pc);
		end
	end

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		expect_t e;
		if (!i_reset) begin
			if (exp_q.size() > 0 && exp_q[0].due == cycle) begin
				e = exp_q.pop_front();
				popped++;
				if (i_wb_valid !== 1'b1) begin
					err_count++;
					$display("missing write-back at %0t: o_wb_valid stayed low", $time);
				end else begin
					compare_value("o_wb_write", 32'(e.write), 32'(i_wb_write));
					compare_value("o_illegal", 32'(e.illegal), 32'(i_illegal));
					compare_value("o_branch_taken", 32'(e.taken), 32'(i_branch_taken));
					if (e.write) begin
						compare_value("o_wb_rd", 32'(e.rd), 32'(i_wb_rd));
						compare_value("o_wb_data", e.data, i_wb_data);
					end
					if (e.has_target) compare_value("o_target", e.target, i_target);
				end
			end else begin
				if (i_wb_valid !== 1'b0) begin
					err_count++;
					$display("unexpected write-back at %0t: o_wb_valid high with nothing due",
						$time);
				end
				compare_value("o_wb_write", 32'd0, 32'(i_wb_write));
				compare_value("o_branch_taken", 32'd0, 32'(i_branch_taken));
				compare_value("o_illegal", 32'd0, 32'(i_illegal));
			end
		end
	end

endmodule

// ==== rtl/rv_decode_exec_top.sv ====
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_decode_exec_top (
	input  logic                  clk,
	input  logic                  i_reset,
	input  logic                  i_valid,
	input  logic [31:0]           i_instr,
	input  logic [`RV_XLEN-1:0]   i_pc,
	output logic                  o_wb_valid,
	output logic                  o_wb_write,
	output logic [`RV_REG_AW-1:0] o_wb_rd,
	output logic [`RV_XLEN-1:0]   o_wb_data,
	output logic                  o_branch_taken,
	output logic [`RV_XLEN-1:0]   o_target,
	output logic                  o_illegal
);
	import rv_pkg::*;

	logic [`RV_REG_AW-1:0] rs1_idx;
	logic [`RV_REG_AW-1:0] rs2_idx;
	word_t                 rs1_data;
	word_t                 rs2_data;
	logic                  rf_we;
	logic [`RV_REG_AW-1:0] rf_waddr;
	word_t                 rf_wdata;

	decode_if dec_bus ();

	instr_decoder u_decoder (
		.clk     (clk),
		.i_reset (i_reset),
		.i_valid (i_valid),
		.i_instr (i_instr),
		.i_pc    (i_pc),
		.dec     (dec_bus.decoder)
	);

	alu_execute u_execute (
		.clk            (clk),
		.i_reset        (i_reset),
		.dec            (dec_bus.execute),
		.o_rs1_idx      (rs1_idx),
		.o_rs2_idx      (rs2_idx),
		.i_rs1_data     (rs1_data),
		.i_rs2_data     (rs2_data),
		.o_rf_we        (rf_we),
		.o_rf_waddr     (rf_waddr),
		.o_rf_wdata     (rf_wdata),
		.o_wb_valid     (o_wb_valid),
		.o_wb_write     (o_wb_write),
		.o_wb_rd        (o_wb_rd),
		.o_wb_data      (o_wb_data),
		.o_branch_taken (o_branch_taken),
		.o_target       (o_target),
		.o_illegal      (o_illegal)
	);

	// written on the same edge that registers the execute outputs
	reg_file u_regs (
		.clk       (clk),
		.i_reset   (i_reset),
		.i_raddr_a (rs1_idx),
		.i_raddr_b (rs2_idx),
		.o_rdata_a (rs1_data),
		.o_rdata_b (rs2_data),
		.i_we      (rf_we),
		.i_waddr   (rf_waddr),
		.i_wdata   (rf_wdata)
	);

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps
`include "rv_macros.svh"

module reg_file (
	input  logic                  clk,
	input  logic                  i_reset,
	input  logic [`RV_REG_AW-1:0] i_raddr_a,
	input  logic [`RV_REG_AW-1:0] i_raddr_b,
	output rv_pkg::word_t         o_rdata_a,
	output rv_pkg::word_t         o_rdata_b,
	input  logic                  i_we,
	input  logic [`RV_REG_AW-1:0] i_waddr,
	input  rv_pkg::word_t         i_wdata
);
	import rv_pkg::*;

	// x0 has no storage
	word_t regs [1:`RV_NUM_REGS-1];

	always_ff @(posedge clk) begin
		if (i_reset) begin
			for (int i = 1; i < `RV_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_we && i_waddr != '0) begin
			regs[i_waddr] <= i_wdata;
		end
	end

	assign o_rdata_a = (i_raddr_a == '0) ? '0 : regs[i_raddr_a];
	assign o_rdata_b = (i_raddr_b == '0) ? '0 : regs[i_raddr_b];

endmodule

// ==== rtl/alu_execute.sv ====
`timescale 1ns/1ps
`include "rv_macros.svh"

module alu_execute (
	input  logic                  clk,
	input  logic                  i_reset,
	decode_if.execute             dec,
	output logic [`RV_REG_AW-1:0] o_rs1_idx,
	output logic [`RV_REG_AW-1:0] o_rs2_idx,
	input  logic [`RV_XLEN-1:0]   i_rs1_data,
	input  logic [`RV_XLEN-1:0]   i_rs2_data,
	output logic                  o_rf_we,
	output logic [`RV_REG_AW-1:0] o_rf_waddr,
	output logic [`RV_XLEN-1:0]   o_rf_wdata,
	output logic                  o_wb_valid,
	output logic                  o_wb_write,
	output logic [`RV_REG_AW-1:0] o_wb_rd,
	output logic [`RV_XLEN-1:0]   o_wb_data,
	output logic                  o_branch_taken,
	output logic [`RV_XLEN-1:0]   o_target,
	output logic                  o_illegal
);
	import rv_pkg::*;

	dec_ctrl_t           ctrl;
	logic [`RV_XLEN-1:0] op_a;
	logic [`RV_XLEN-1:0] op_b;
	logic [4:0]          shamt;
	logic                lt_s;
	logic                lt_u;
	logic                cmp_true;
	logic [`RV_XLEN-1:0] alu_res;
	logic [`RV_XLEN-1:0] wb_data;
	logic [`RV_XLEN-1:0] target;
	logic                taken;

	assign ctrl = dec.ctrl;
	assign o_rs1_idx = ctrl.rs1;
	assign o_rs2_idx = ctrl.rs2;

	// auipc is the only u-format add, lui ignores op_a
	assign op_a = (ctrl.fmt == FMT_U) ? ctrl.pc : i_rs1_data;
	assign op_b = ctrl.use_imm ? ctrl.imm : i_rs2_data;
	assign shamt = op_b[4:0];
	assign lt_s = $signed(op_a) < $signed(op_b);
	assign lt_u = op_a < op_b;

	always_comb begin
		case (ctrl.alu_op)
			ALU_EQ:  cmp_true = (op_a == op_b);
			ALU_NE:  cmp_true = (op_a != op_b);
			ALU_LT:  cmp_true = lt_s;
			ALU_GE:  cmp_true = !lt_s;
			ALU_LTU: cmp_true = lt_u;
			ALU_GEU: cmp_true = !lt_u;
			default: cmp_true = 1'b0;
		endcase
	end

	always_comb begin
		case (ctrl.alu_op)
			ALU_ADD:      alu_res = op_a + op_b;
			ALU_SUB:      alu_res = op_a - op_b;
			ALU_SLL:      alu_res = op_a << shamt;
			ALU_SLT:      alu_res = {{(`RV_XLEN-1){1'b0}}, lt_s};
			ALU_SLTU:     alu_res = {{(`RV_XLEN-1){1'b0}}, lt_u};
			ALU_XOR:      alu_res = op_a ^ op_b;
			ALU_SRL:      alu_res = op_a >> shamt;
			ALU_SRA:      alu_res = $unsigned($signed(op_a) >>> shamt);
			ALU_OR:       alu_res = op_a | op_b;
			ALU_AND:      alu_res = op_a & op_b;
			ALU_PASS_IMM: alu_res = op_b;
			default:      alu_res = {{(`RV_XLEN-1){1'b0}}, cmp_true};
		endcase
	end

	// jumps link pc+4, anything without a write reports zero
	always_comb begin
		if (!ctrl.reg_write) begin
			wb_data = '0;
		end else if (ctrl.is_jump) begin
			wb_data = ctrl.pc + `RV_XLEN'd4;
		end else begin
			wb_data = alu_res;
		end
	end

	// jalr target is rs1+imm from the adder with bit 0 cleared
	always_comb begin
		if (ctrl.is_jump && ctrl.fmt == FMT_I) begin
			target = {alu_res[`RV_XLEN-1:1], 1'b0};
		end else if (ctrl.is_jump || ctrl.is_branch) begin
			target = ctrl.pc + ctrl.imm;
		end else begin
			target = '0;
		end
	end

	assign taken = ctrl.is_jump | (ctrl.is_branch & cmp_true);

	assign o_rf_we = dec.valid & ctrl.reg_write;
	assign o_rf_waddr = ctrl.rd;
	assign o_rf_wdata = wb_data;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_wb_valid <= 1'b0;
			o_wb_write <= 1'b0;
			o_branch_taken <= 1'b0;
			o_illegal <= 1'b0;
		end else begin
			o_wb_valid <= dec.valid;
			o_wb_write <= o_rf_we;
			o_branch_taken <= dec.valid & taken;
			o_illegal <= dec.valid & ctrl.illegal;
		end
	end

	always_ff @(posedge clk) begin
		if (dec.valid) begin
			o_wb_rd <= ctrl.rd;
			o_wb_data <= wb_data;
			o_target <= target;
		end
	end

endmodule

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/1ps
`include "rv_macros.svh"

module instr_decoder (
	input  logic                clk,
	input  logic                i_reset,
	input  logic                i_valid,
	input  logic [31:0]         i_instr,
	input  logic [`RV_XLEN-1:0] i_pc,
	decode_if.decoder           dec
);
	import rv_pkg::*;

	opcode_e             opcode;
	logic [2:0]          funct3;
	logic [6:0]          funct7;
	logic [`RV_XLEN-1:0] imm_i;
	logic [`RV_XLEN-1:0] imm_u;
	logic [`RV_XLEN-1:0] imm_j;
	logic [`RV_XLEN-1:0] imm_b;
	logic [`RV_XLEN-1:0] imm_shamt;
	dec_ctrl_t           ctrl_d;

	// funct3 map shared by register and immediate arithmetic
	function automatic alu_op_e base_alu_op(input logic [2:0] f3);
		alu_op_e op;
		case (f3)
			3'b000:  op = ALU_ADD;
			3'b001:  op = ALU_SLL;
			3'b010:  op = ALU_SLT;
			3'b011:  op = ALU_SLTU;
			3'b100:  op = ALU_XOR;
			3'b101:  op = ALU_SRL;
			3'b110:  op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	assign opcode = opcode_e'(i_instr[6:0]);
	assign funct3 = i_instr[14:12];
	assign funct7 = i_instr[31:25];

	// sign-extended immediates for each format
	assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
	assign imm_u = {i_instr[31:12], 12'b0};
	assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
	assign imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
	assign imm_shamt = {{(`RV_XLEN-5){1'b0}}, i_instr[24:20]};

	always_comb begin
		ctrl_d = '0;
		ctrl_d.rd = i_instr[11:7];
		ctrl_d.rs1 = i_instr[19:15];
		ctrl_d.rs2 = i_instr[24:20];
		ctrl_d.pc = i_pc;
		ctrl_d.alu_op = ALU_ADD;
		ctrl_d.fmt = FMT_NONE;

		case (opcode)
			OP: begin
				ctrl_d.fmt = FMT_R;
				ctrl_d.reg_write = 1'b1;
				if (funct7 == 7'b0000000) begin
					ctrl_d.alu_op = base_alu_op(funct3);
				end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
					ctrl_d.alu_op = ALU_SUB;
				end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
					ctrl_d.alu_op = ALU_SRA;
				end else begin
					ctrl_d.illegal = 1'b1;
				end
			end
			OP_IMM: begin
				ctrl_d.fmt = FMT_I;
				ctrl_d.reg_write = 1'b1;
				ctrl_d.use_imm = 1'b1;
				ctrl_d.imm = imm_i;
				ctrl_d.alu_op = base_alu_op(funct3);
				// shifts only take the low five bits as shift amount
				if (funct3 == 3'b001) begin
					ctrl_d.imm = imm_shamt;
					ctrl_d.illegal = (funct7 != 7'b0000000);
				end else if (funct3 == 3'b101) begin
					ctrl_d.imm = imm_shamt;
					if (funct7 == 7'b0100000) begin
						ctrl_d.alu_op = ALU_SRA;
					end else if (funct7 != 7'b0000000) begin
						ctrl_d.illegal = 1'b1;
					end
				end
			end
			LUI: begin
				ctrl_d.fmt = FMT_U;
				ctrl_d.reg_write = 1'b1;
				ctrl_d.use_imm = 1'b1;
				ctrl_d.imm = imm_u;
				ctrl_d.alu_op = ALU_PASS_IMM;
			end
			AUIPC: begin
				// add of pc and immediate, execute picks pc as first operand
				ctrl_d.fmt = FMT_U;
				ctrl_d.reg_write = 1'b1;
				ctrl_d.use_imm = 1'b1;
				ctrl_d.imm = imm_u;
			end
			JAL: begin
				ctrl_d.fmt = FMT_J;
				ctrl_d.reg_write = 1'b1;
				ctrl_d.is_jump = 1'b1;
				ctrl_d.imm = imm_j;
			end
			JALR: begin
				ctrl_d.fmt = FMT_I;
				ctrl_d.reg_write = 1'b1;
				ctrl_d.is_jump = 1'b1;
				ctrl_d.use_imm = 1'b1;
				ctrl_d.imm = imm_i;
				ctrl_d.illegal = (funct3 != 3'b000);
			end
			BRANCH: begin
				ctrl_d.fmt = FMT_B;
				ctrl_d.is_branch = 1'b1;
				ctrl_d.imm = imm_b;
				case (funct3)
					3'b000:  ctrl_d.alu_op = ALU_EQ;
					3'b001:  ctrl_d.alu_op = ALU_NE;
					3'b100:  ctrl_d.alu_op = ALU_LT;
					3'b101:  ctrl_d.alu_op = ALU_GE;
					3'b110:  ctrl_d.alu_op = ALU_LTU;
					3'b111:  ctrl_d.alu_op = ALU_GEU;
					default: ctrl_d.illegal = 1'b1;
				endcase
			end
			default: begin
				ctrl_d.illegal = 1'b1;
			end
		endcase

		// an illegal word has no side effects downstream
		if (ctrl_d.illegal) begin
			ctrl_d.reg_write = 1'b0;
			ctrl_d.is_jump = 1'b0;
			ctrl_d.is_branch = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			dec.valid <= 1'b0;
		end else begin
			dec.valid <= i_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (i_valid) begin
			dec.ctrl <= ctrl_d;
		end
	end

endmodule

// ==== rtl/decode_if.sv ====
`timescale 1ns/1ps

interface decode_if;
	import rv_pkg::*;

	// one decoded instruction, qualified by valid
	logic      valid;
	dec_ctrl_t ctrl;

	modport decoder (
		output valid,
		output ctrl
	);

	// execute acts on ctrl only while valid is high
	modport execute (
		input valid,
		input ctrl
	);

endinterface

// ==== rtl/rv_pkg.sv ====
`include "rv_macros.svh"

package rv_pkg;

	typedef logic [`RV_XLEN-1:0] word_t;

	// major opcodes of the kept RV32I subset
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		BRANCH = 7'b1100011
	} opcode_e;

	typedef enum logic [4:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		// lui result is the immediate itself
		ALU_PASS_IMM,
		// branch compares produce a single result bit
		ALU_EQ,
		ALU_NE,
		ALU_LT,
		ALU_GE,
		ALU_LTU,
		ALU_GEU
	} alu_op_e;

	typedef enum logic [2:0] {
		FMT_R,
		FMT_I,
		FMT_U,
		FMT_J,
		FMT_B,
		FMT_NONE
	} instr_fmt_e;

	typedef struct packed {
		logic [`RV_REG_AW-1:0] rd;
		logic [`RV_REG_AW-1:0] rs1;
		logic [`RV_REG_AW-1:0] rs2;
		logic [`RV_XLEN-1:0]   imm;
		alu_op_e               alu_op;
		instr_fmt_e            fmt;
		logic [`RV_XLEN-1:0]   pc;
		logic                  use_imm;
		logic                  reg_write;
		logic                  is_branch;
		logic                  is_jump;
		logic                  illegal;
	} dec_ctrl_t;

endpackage

// ==== rtl/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// data path and address width
`define RV_XLEN 32

// architectural register file size
`define RV_NUM_REGS 32
`define RV_REG_AW 5

`endif
